/* include/datapath_params.svh */
/*
 * Datapath sizing
 * bus width, general register count and RAM geometry
 */

`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

`define DATA_WIDTH 32
`define REG_COUNT 16
`define MEM_DEPTH 512
// low MAR bits that address the RAM
`define MEM_ADDR_WIDTH 9

`endif

/* hw/datapath_pkg.sv */
/*
 * Datapath types
 * bus word, ALU opcodes and bus source codes shared by the datapath blocks
 */

`include "datapath_params.svh"

package datapath_pkg;

  typedef logic [`DATA_WIDTH-1:0] word_t;

  // opcode as driven by the external control steps
  typedef enum logic [4:0] {
    ADD  = 5'd0,
    SUB  = 5'd1,
    AND  = 5'd2,
    OR   = 5'd3,
    SHR  = 5'd4,
    SHRA = 5'd5,
    SHL  = 5'd6,
    ROR  = 5'd7,
    ROL  = 5'd8,
    MUL  = 5'd9,
    DIV  = 5'd10,
    NEG  = 5'd11,
    NOT  = 5'd12
  } aluOp_t;

  // bus encoder output in priority order
  typedef enum logic [3:0] {
    REG, HI, LO, ZHI, ZLO, PC, MDR, INPORT, CSIGN, NONE
  } busSrc_t;

endpackage

/* hw/regSel_if.sv */
/*
 * Register select interface
 * decoded register enables from select-and-encode to the register file and bus
 */

`timescale 1ns/100ps

`include "datapath_params.svh"

interface regSel_if;
  logic [`REG_COUNT-1:0] writeEn;
  logic [`REG_COUNT-1:0] readEn;
  logic readAny;
  // baOut applied to R0
  logic zeroR0;

  modport encoder (output writeEn, output readEn, output readAny, output zeroR0);
  modport regFile (input writeEn, input readEn, input zeroR0);
  modport bus (input readAny);
endinterface

/* hw/selectEncode.sv */
/*
 * Select and encode
 * turns the IR register fields into one-hot register enables
 * and sign-extends the IR constant field
 */

`timescale 1ns/100ps

`include "datapath_params.svh"

module selectEncode import datapath_pkg::*; (
  input  word_t    ir,
  input  logic     gra,
  input  logic     grb,
  input  logic     grc,
  input  logic     rIn,
  input  logic     rOut,
  input  logic     baOut,
  regSel_if.encoder sel,
  output word_t    cSignExt
);

  logic [3:0] ra;
  logic [3:0] rb;
  logic [3:0] rc;
  logic [`REG_COUNT-1:0] decoded;

  assign ra = ir[26:23];
  assign rb = ir[22:19];
  assign rc = ir[18:15];

  // several field selects at once give an OR of their decodes
  always_comb begin
    decoded = '0;
    if (gra) decoded[ra] = 1'b1;
    if (grb) decoded[rb] = 1'b1;
    if (grc) decoded[rc] = 1'b1;
  end

  assign sel.writeEn = rIn ? decoded : '0;
  assign sel.readEn  = (rOut || baOut) ? decoded : '0;
  assign sel.readAny = |sel.readEn;
  assign sel.zeroR0  = baOut;

  // C field is IR[18:0]
  assign cSignExt = {{(`DATA_WIDTH-19){ir[18]}}, ir[18:0]};

endmodule

/* hw/regFile.sv */
/*
 * Register file
 * R0 to R15 plus HI and LO, all loaded from the bus
 */

`timescale 1ns/100ps

`include "datapath_params.svh"

module regFile import datapath_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  regSel_if.regFile sel,
  input  word_t    busIn,
  input  logic     hiIn,
  input  logic     loIn,
  output word_t    readData,
  output word_t    hiData,
  output word_t    loData
);

  word_t gpr [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        gpr[i] <= '0;
      end
      hiData <= '0;
      loData <= '0;
    end else begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        if (sel.writeEn[i]) gpr[i] <= busIn;
      end
      if (hiIn) hiData <= busIn;
      if (loIn) loData <= busIn;
    end
  end

  // one-hot read where R0 reads as zero under baOut
  always_comb begin
    readData = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      if (sel.readEn[i] && !(i == 0 && sel.zeroR0)) begin
        readData = readData | gpr[i];
      end
    end
  end

endmodule

/* hw/alu.sv */
/*
 * ALU
 * combinational, 64-bit result split into the halves that Z captures
 * a comes from Y, b from the bus
 */

`timescale 1ns/100ps

`include "datapath_params.svh"

module alu import datapath_pkg::*; (
  input  word_t  a,
  input  word_t  b,
  input  aluOp_t op,
  input  logic   incPc,
  output word_t  resultHi,
  output word_t  resultLo
);

  logic [4:0] shamt;
  logic signed [2*`DATA_WIDTH-1:0] product;
  word_t quotient;
  word_t remainder;
  logic [2*`DATA_WIDTH-1:0] rotRight;
  logic [2*`DATA_WIDTH-1:0] rotLeft;

  assign shamt   = b[4:0];
  assign product = $signed(a) * $signed(b);

  // divide by zero yields zero quotient and remainder
  always_comb begin
    if (b == '0) begin
      quotient  = '0;
      remainder = '0;
    end else begin
      quotient  = $signed(a) / $signed(b);
      remainder = $signed(a) % $signed(b);
    end
  end

  // rotate through a doubled copy of a
  assign rotRight = {a, a} >> shamt;
  assign rotLeft  = {a, a} << shamt;

  always_comb begin
    resultHi = '0;
    resultLo = '0;
    if (incPc) begin
      // PC increment path wins over the opcode
      resultLo = b + 1'b1;
    end else begin
      case (op)
        ADD:  resultLo = a + b;
        SUB:  resultLo = a - b;
        AND:  resultLo = a & b;
        OR:   resultLo = a | b;
        SHR:  resultLo = a >> shamt;
        SHRA: resultLo = $signed(a) >>> shamt;
        SHL:  resultLo = a << shamt;
        ROR:  resultLo = rotRight[`DATA_WIDTH-1:0];
        ROL:  resultLo = rotLeft[2*`DATA_WIDTH-1:`DATA_WIDTH];
        MUL: begin
          resultHi = product[2*`DATA_WIDTH-1:`DATA_WIDTH];
          resultLo = product[`DATA_WIDTH-1:0];
        end
        DIV: begin
          resultHi = remainder;
          resultLo = quotient;
        end
        NEG:  resultLo = -b;
        NOT:  resultLo = ~b;
        default: resultLo = '0;
      endcase
    end
  end

endmodule

/* hw/busMux.sv */
/*
 * Bus multiplexer
 * priority-encodes the out strobes and drives the shared bus
 */

`timescale 1ns/100ps

module busMux import datapath_pkg::*; (
  regSel_if.bus sel,
  input  word_t regData,
  input  word_t hiData,
  input  word_t loData,
  input  word_t zHiData,
  input  word_t zLoData,
  input  word_t pcData,
  input  word_t mdrData,
  input  word_t inPortData,
  input  word_t cSignExt,
  input  logic  hiOut,
  input  logic  loOut,
  input  logic  zHighOut,
  input  logic  zLowOut,
  input  logic  pcOut,
  input  logic  mdrOut,
  input  logic  inPortOut,
  input  logic  cOut,
  output word_t busOut
);

  busSrc_t src;

  // register path has the highest priority
  always_comb begin
    if (sel.readAny)     src = REG;
    else if (hiOut)      src = HI;
    else if (loOut)      src = LO;
    else if (zHighOut)   src = ZHI;
    else if (zLowOut)    src = ZLO;
    else if (pcOut)      src = PC;
    else if (mdrOut)     src = MDR;
    else if (inPortOut)  src = INPORT;
    else if (cOut)       src = CSIGN;
    else                 src = NONE;
  end

  always_comb begin
    case (src)
      REG:     busOut = regData;
      HI:      busOut = hiData;
      LO:      busOut = loData;
      ZHI:     busOut = zHiData;
      ZLO:     busOut = zLoData;
      PC:      busOut = pcData;
      MDR:     busOut = mdrData;
      INPORT:  busOut = inPortData;
      CSIGN:   busOut = cSignExt;
      default: busOut = '0;
    endcase
  end

endmodule

/* hw/memUnit.sv */
/*
 * Memory unit
 * MAR, MDR and a word RAM with asynchronous read
 */

`timescale 1ns/100ps

`include "datapath_params.svh"

module memUnit import datapath_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  marIn,
  input  logic  mdrIn,
  input  logic  read,
  input  logic  write,
  input  word_t busIn,
  output word_t mdrData
);

  word_t mar;
  word_t ram [`MEM_DEPTH];
  logic [`MEM_ADDR_WIDTH-1:0] addr;

  assign addr = mar[`MEM_ADDR_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      mar     <= '0;
      mdrData <= '0;
    end else begin
      if (marIn) mar <= busIn;
      // read picks RAM over the bus as MDR source
      if (mdrIn) mdrData <= read ? ram[addr] : busIn;
    end
  end

  // store path writes MDR into RAM at MAR
  always_ff @(posedge clk) begin
    if (write) ram[addr] <= mdrData;
  end

endmodule

/* hw/conFf.sv */
/*
 * Branch condition flip-flop
 * tests the bus against the IR condition code and holds CON
 */

`timescale 1ns/100ps

`include "datapath_params.svh"

module conFf import datapath_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       conIn,
  input  logic [1:0] cond,
  input  word_t      busIn,
  output logic       conFlag
);

  logic condMet;

  always_comb begin
    case (cond)
      2'd0: condMet = (busIn == '0);
      2'd1: condMet = (busIn != '0);
      2'd2: condMet = !busIn[`DATA_WIDTH-1];
      default: condMet = busIn[`DATA_WIDTH-1];
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) conFlag <= 1'b0;
    else if (conIn) conFlag <= condMet;
  end

endmodule

/* hw/miniDatapath.sv */
/*
 * Single-bus datapath, top level
 * PC, IR, Y, Z and the ports around the register file, ALU and memory
 * control strobes come straight from outside
 */

`timescale 1ns/100ps

module miniDatapath import datapath_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  // out strobes
  input  logic   pcOut,
  input  logic   zHighOut,
  input  logic   zLowOut,
  input  logic   mdrOut,
  input  logic   hiOut,
  input  logic   loOut,
  input  logic   inPortOut,
  input  logic   cOut,
  // in strobes
  input  logic   marIn,
  input  logic   mdrIn,
  input  logic   irIn,
  input  logic   yIn,
  input  logic   zIn,
  input  logic   pcIn,
  input  logic   hiIn,
  input  logic   loIn,
  input  logic   outPortIn,
  input  logic   conIn,
  // memory and PC control
  input  logic   read,
  input  logic   write,
  input  logic   incPc,
  // register select
  input  logic   gra,
  input  logic   grb,
  input  logic   grc,
  input  logic   rIn,
  input  logic   rOut,
  input  logic   baOut,
  input  aluOp_t aluOp,
  input  word_t  inPortData,
  output word_t  busOut,
  output word_t  outPortData,
  output logic   conFlag
);

  word_t pc;
  word_t ir;
  word_t y;
  word_t zHi;
  word_t zLo;
  word_t aluHi;
  word_t aluLo;
  word_t regData;
  word_t hiData;
  word_t loData;
  word_t mdrData;
  word_t cSignExt;

  regSel_if regSel ();

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      ir          <= '0;
      y           <= '0;
      zHi         <= '0;
      zLo         <= '0;
      outPortData <= '0;
    end else begin
      if (pcIn) pc <= busOut;
      if (irIn) ir <= busOut;
      if (yIn) y <= busOut;
      // both Z halves load together
      if (zIn) begin
        zHi <= aluHi;
        zLo <= aluLo;
      end
      if (outPortIn) outPortData <= busOut;
    end
  end

  selectEncode selEnc (
    .ir       (ir),
    .gra      (gra),
    .grb      (grb),
    .grc      (grc),
    .rIn      (rIn),
    .rOut     (rOut),
    .baOut    (baOut),
    .sel      (regSel.encoder),
    .cSignExt (cSignExt)
  );

  regFile regs (
    .clk      (clk),
    .reset    (reset),
    .sel      (regSel.regFile),
    .busIn    (busOut),
    .hiIn     (hiIn),
    .loIn     (loIn),
    .readData (regData),
    .hiData   (hiData),
    .loData   (loData)
  );

  alu aluUnit (
    .a        (y),
    .b        (busOut),
    .op       (aluOp),
    .incPc    (incPc),
    .resultHi (aluHi),
    .resultLo (aluLo)
  );

  busMux bus (
    .sel        (regSel.bus),
    .regData    (regData),
    .hiData     (hiData),
    .loData     (loData),
    .zHiData    (zHi),
    .zLoData    (zLo),
    .pcData     (pc),
    .mdrData    (mdrData),
    .inPortData (inPortData),
    .cSignExt   (cSignExt),
    .hiOut      (hiOut),
    .loOut      (loOut),
    .zHighOut   (zHighOut),
    .zLowOut    (zLowOut),
    .pcOut      (pcOut),
    .mdrOut     (mdrOut),
    .inPortOut  (inPortOut),
    .cOut       (cOut),
    .busOut     (busOut)
  );

  memUnit mem (
    .clk     (clk),
    .reset   (reset),
    .marIn   (marIn),
    .mdrIn   (mdrIn),
    .read    (read),
    .write   (write),
    .busIn   (busOut),
    .mdrData (mdrData)
  );

  // condition code sits in IR[20:19]
  conFf con (
    .clk     (clk),
    .reset   (reset),
    .conIn   (conIn),
    .cond    (ir[20:19]),
    .busIn   (busOut),
    .conFlag (conFlag)
  );

endmodule

/* sim/miniDatapath_chk.sv */
/*
 * Datapath assertions
 * reset, idle bus and memory write-then-read checks on the top level
 */

`timescale 1ns/100ps

module miniDatapath_chk import datapath_pkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  conFlag,
  input logic  pcOut,
  input logic  zHighOut,
  input logic  zLowOut,
  input logic  mdrOut,
  input logic  hiOut,
  input logic  loOut,
  input logic  inPortOut,
  input logic  cOut,
  input logic  rOut,
  input logic  baOut,
  input logic  read,
  input logic  write,
  input logic  mdrIn,
  input logic  marIn,
  input word_t busOut,
  input word_t mdrData
);

  logic anyOut;

  assign anyOut = pcOut | zHighOut | zLowOut | mdrOut | hiOut | loOut |
                  inPortOut | cOut | rOut | baOut;

  conClearedByReset: assert property (@(posedge clk) reset |=> !conFlag)
    else $error("conFlag set in the cycle after reset");

  idleBusZero: assert property (@(posedge clk) disable iff (reset)
      !anyOut |-> busOut == '0)
    else $error("bus not zero with no source enabled");

  // a write followed by a read into MDR on the next cycle with MAR held
  readBackWritten: assert property (@(posedge clk) disable iff (reset)
      (read && mdrIn && !marIn && $past(write && !marIn)) |=> mdrData == $past(mdrData, 2))
    else $error("MDR read back differs from the word written at the same address");

endmodule

bind miniDatapath miniDatapath_chk chk (.*);

/* sim/miniDatapath_tb.sv */
/*
 * Testbench for the single-bus datapath
 * steps the external control strobes through a table of ALU operations,
 * then register, memory, PC and branch condition sequences
 */

`timescale 1ns/100ps

module miniDatapath_tb import datapath_pkg::*; ();

  localparam int PERIOD = 100;
  localparam int NUM_ROWS = 16;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 12 + 200;
  localparam word_t SEED = 32'h5cf2_e75b;

  logic clk;
  logic reset;
  logic pcOut, zHighOut, zLowOut, mdrOut, hiOut, loOut, inPortOut, cOut;
  logic marIn, mdrIn, irIn, yIn, zIn, pcIn, hiIn, loIn, outPortIn, conIn;
  logic read, write, incPc;
  logic gra, grb, grc, rIn, rOut, baOut;
  aluOp_t aluOp;
  word_t inPortData;
  word_t busOut;
  word_t outPortData;
  logic conFlag;

  // stimulus table of IR, opcode, operands and random operand flag
  word_t  irTab  [NUM_ROWS];
  aluOp_t opTab  [NUM_ROWS];
  word_t  aTab   [NUM_ROWS];
  word_t  bTab   [NUM_ROWS];
  logic   rndTab [NUM_ROWS];

  string srcNames [6] = '{"busOut (PC)", "busOut (Z high)", "busOut (Z low)",
                          "busOut (HI)", "busOut (LO)", "busOut (MDR)"};
  word_t conVals [4] = '{32'h0000_0000, 32'h8000_0003, 32'h7fff_ffff, 32'h0000_0005};

  word_t rng;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  miniDatapath uut (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic word_t xorshift(word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t packIr(logic [3:0] ra, logic [3:0] rb, logic [3:0] rc);
    return {5'b0, ra, rb, rc, 15'b0};
  endfunction

  // expected {Z high, Z low} of one ALU operation with a from Y and b from the bus
  function automatic logic [63:0] refAlu(aluOp_t op, word_t a, word_t b);
    int sa;
    int sb;
    logic [4:0] n;
    longint prod;
    logic [63:0] r;
    sa = a;
    sb = b;
    n = b[4:0];
    r = '0;
    case (op)
      ADD:  r = {32'h0, a + b};
      SUB:  r = {32'h0, a - b};
      AND:  r = {32'h0, a & b};
      OR:   r = {32'h0, a | b};
      SHR:  r = {32'h0, a >> n};
      SHRA: r = {32'h0, word_t'(sa >>> n)};
      SHL:  r = {32'h0, a << n};
      ROR:  r = {32'h0, (a >> n) | (a << (32 - n))};
      ROL:  r = {32'h0, (a << n) | (a >> (32 - n))};
      MUL: begin
        prod = longint'(sa) * longint'(sb);
        r = prod;
      end
      DIV:  r = {word_t'(sa % sb), word_t'(sa / sb)};
      NEG:  r = {32'h0, word_t'(-sb)};
      NOT:  r = {32'h0, ~b};
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic condHolds(logic [1:0] c, word_t v);
    case (c)
      2'd0: return v == 32'h0;
      2'd1: return v != 32'h0;
      2'd2: return !v[31];
      default: return v[31];
    endcase
  endfunction

  task automatic setRow(int i, logic [3:0] ra, logic [3:0] rb, logic [3:0] rc,
                        aluOp_t op, word_t a, word_t b, logic rnd);
    irTab[i] = packIr(ra, rb, rc);
    opTab[i] = op;
    aTab[i] = a;
    bTab[i] = b;
    rndTab[i] = rnd;
  endtask

  task automatic fillTable();
    setRow(0, 1, 2, 3, ADD, 32'h1234_5678, 32'h0fed_cba9, 0);
    setRow(1, 4, 5, 6, SUB, 32'h0000_0010, 32'h0000_0020, 0);
    setRow(2, 7, 8, 9, AND, 32'hf0f0_1234, 32'h0ff0_ffff, 0);
    setRow(3, 10, 11, 12, OR, 32'h1200_0000, 32'h0034_5678, 0);
    // shift count comes from the low 5 bits only
    setRow(4, 13, 14, 15, SHR, 32'h8000_0f00, 32'h0000_0024, 0);
    setRow(5, 1, 3, 5, SHRA, 32'h8000_0f00, 32'h0000_0004, 0);
    setRow(6, 2, 4, 6, SHL, 32'h0000_00ff, 32'h0000_0008, 0);
    setRow(7, 3, 6, 9, ROR, 32'h1234_5678, 32'h0000_0008, 0);
    setRow(8, 4, 8, 12, ROL, 32'h1234_5678, 32'h0000_000c, 0);
    setRow(9, 5, 10, 15, MUL, 32'hffff_fffe, 32'h0000_1000, 0);
    setRow(10, 6, 12, 2, DIV, 32'hffff_ff9c, 32'h0000_0007, 0);
    setRow(11, 7, 14, 1, NEG, 32'h0000_0000, 32'h0000_0005, 0);
    setRow(12, 8, 1, 2, NOT, 32'h0000_0000, 32'h5555_aaaa, 0);
    setRow(13, 9, 11, 13, MUL, 32'h0, 32'h0, 1);
    setRow(14, 14, 3, 7, DIV, 32'h0, 32'h0, 1);
    setRow(15, 15, 9, 10, ROR, 32'h0, 32'h0, 1);
  endtask

  task automatic clearControls();
    {pcOut, zHighOut, zLowOut, mdrOut, hiOut, loOut, inPortOut, cOut} = '0;
    {marIn, mdrIn, irIn, yIn, zIn, pcIn, hiIn, loIn, outPortIn, conIn} = '0;
    {read, write, incPc, gra, grb, grc, rIn, rOut, baOut} = '0;
    aluOp = ADD;
  endtask

  // one control step lasts from a falling edge to the next one
  task automatic nextStep();
    @(negedge clk);
    clearControls();
  endtask

  task automatic settle();
    #(PERIOD / 4);
  endtask

  task automatic sampleBus(output word_t v);
    settle();
    v = busOut;
  endtask

  task automatic selectField(int f);
    gra = (f == 0);
    grb = (f == 1);
    grc = (f == 2);
  endtask

  task automatic loadIr(word_t v);
    nextStep();
    inPortData = v;
    inPortOut = 1'b1;
    irIn = 1'b1;
  endtask

  // f picks the field as 0 for Ra, 1 for Rb and 2 for Rc
  task automatic portToReg(int f, word_t v);
    nextStep();
    inPortData = v;
    inPortOut = 1'b1;
    rIn = 1'b1;
    selectField(f);
  endtask

  task automatic readReg(int f, output word_t v);
    nextStep();
    rOut = 1'b1;
    selectField(f);
    sampleBus(v);
  endtask

  task automatic readSource(int s, output word_t v);
    nextStep();
    case (s)
      0: pcOut = 1'b1;
      1: zHighOut = 1'b1;
      2: zLowOut = 1'b1;
      3: hiOut = 1'b1;
      4: loOut = 1'b1;
      default: mdrOut = 1'b1;
    endcase
    sampleBus(v);
  endtask

  task automatic checkValue(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  initial begin
    word_t v;
    word_t a;
    word_t b;
    word_t addr;
    word_t data;
    word_t irVal;
    word_t pcStart;
    logic [63:0] expAlu;
    rng = SEED;
    fillTable();
    clearControls();
    inPortData = '0;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // everything reads zero after reset
    checkValue("conFlag", {31'b0, conFlag}, 32'h0);
    for (int s = 0; s < 6; s++) begin
      readSource(s, v);
      checkValue(srcNames[s], v, 32'h0);
    end
    for (int r = 0; r < 16; r++) begin
      loadIr(packIr(4'(r), 4'd0, 4'd0));
      readReg(0, v);
      checkValue($sformatf("busOut (R%0d)", r), v, 32'h0);
    end

    // ALU table rows with Rb into Y, Rc onto the bus and the result through Z low into Ra
    for (int i = 0; i < NUM_ROWS; i++) begin
      a = aTab[i];
      b = bTab[i];
      if (rndTab[i]) begin
        rng = xorshift(rng);
        a = rng;
        rng = xorshift(rng);
        b = rng;
        if (opTab[i] == DIV) b = (b & 32'h0000_ffff) | 32'h1;
      end
      expAlu = refAlu(opTab[i], a, b);
      loadIr(irTab[i]);
      portToReg(1, a);
      portToReg(2, b);
      nextStep();
      selectField(1);
      rOut = 1'b1;
      yIn = 1'b1;
      nextStep();
      selectField(2);
      rOut = 1'b1;
      aluOp = opTab[i];
      zIn = 1'b1;
      nextStep();
      zLowOut = 1'b1;
      selectField(0);
      rIn = 1'b1;
      readReg(0, v);
      checkValue($sformatf("busOut (Ra, %s)", opTab[i].name()), v, expAlu[31:0]);
      if (opTab[i] == MUL || opTab[i] == DIV) begin
        readSource(1, v);
        checkValue($sformatf("busOut (Z high, %s)", opTab[i].name()), v, expAlu[63:32]);
      end
    end

    // R0 under baOut, a nonzero register under rOut, and the constant
    irVal = {5'b0, 4'd0, 4'd7, 19'h4_1a2b};
    loadIr(irVal);
    portToReg(0, 32'h1234_5678);
    nextStep();
    gra = 1'b1;
    baOut = 1'b1;
    sampleBus(v);
    checkValue("busOut (R0 with baOut)", v, 32'h0);
    readReg(0, v);
    checkValue("busOut (R0 with rOut)", v, 32'h1234_5678);
    portToReg(1, 32'h0bad_f00d);
    readReg(1, v);
    checkValue("busOut (R7)", v, 32'h0bad_f00d);
    nextStep();
    cOut = 1'b1;
    sampleBus(v);
    checkValue("busOut (constant)", v, 32'hfffc_1a2b);

    // HI and LO load from the bus
    nextStep();
    inPortData = 32'hcafe_0001;
    inPortOut = 1'b1;
    hiIn = 1'b1;
    nextStep();
    inPortData = 32'h0001_cafe;
    inPortOut = 1'b1;
    loIn = 1'b1;
    readSource(3, v);
    checkValue("busOut (HI)", v, 32'hcafe_0001);
    readSource(4, v);
    checkValue("busOut (LO)", v, 32'h0001_cafe);

    // memory write, then read back into a cleared MDR
    for (int k = 0; k < 4; k++) begin
      rng = xorshift(rng);
      addr = rng;
      rng = xorshift(rng);
      data = rng;
      nextStep();
      inPortData = addr;
      inPortOut = 1'b1;
      marIn = 1'b1;
      nextStep();
      inPortData = data;
      inPortOut = 1'b1;
      mdrIn = 1'b1;
      // idle bus clears MDR on the same edge that stores it
      nextStep();
      write = 1'b1;
      mdrIn = 1'b1;
      nextStep();
      read = 1'b1;
      mdrIn = 1'b1;
      mdrOut = 1'b1;
      sampleBus(v);
      checkValue("busOut (MDR cleared)", v, 32'h0);
      readSource(5, v);
      checkValue("busOut (MDR read)", v, data);
    end

    // PC increments through Z while incPc overrides the opcode
    rng = xorshift(rng);
    pcStart = rng;
    nextStep();
    inPortData = pcStart;
    inPortOut = 1'b1;
    pcIn = 1'b1;
    for (int k = 1; k <= 4; k++) begin
      nextStep();
      pcOut = 1'b1;
      incPc = 1'b1;
      aluOp = SUB;
      zIn = 1'b1;
      nextStep();
      zLowOut = 1'b1;
      pcIn = 1'b1;
      readSource(0, v);
      checkValue("busOut (PC)", v, pcStart + word_t'(k));
    end
    rng = xorshift(rng);
    nextStep();
    inPortData = rng;
    inPortOut = 1'b1;
    outPortIn = 1'b1;
    nextStep();
    settle();
    checkValue("outPortData", outPortData, rng);

    // branch condition from IR[20:19] against bus values
    for (int c = 0; c < 4; c++) begin
      loadIr({11'b0, 2'(c), 19'b0});
      for (int k = 0; k < 4; k++) begin
        nextStep();
        inPortData = conVals[k];
        inPortOut = 1'b1;
        conIn = 1'b1;
        nextStep();
        settle();
        checkValue($sformatf("conFlag (cond %0d)", c), {31'b0, conFlag},
                   {31'b0, condHolds(2'(c), conVals[k])});
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
hw/datapath_pkg.sv
hw/regSel_if.sv
hw/selectEncode.sv
hw/regFile.sv
hw/alu.sv
hw/busMux.sv
hw/memUnit.sv
hw/conFf.sv
hw/miniDatapath.sv
sim/miniDatapath_chk.sv
sim/miniDatapath_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= miniDatapath_tb
FILELIST  ?= filelist.f
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
